// File: vlog.f
+incdir+common
common/tlx_cmd_pkg.sv
common/credit_if.sv
source/cmd_queue.sv
issue/cmd_issue.sv
issue/credit_tracker.sv
source/tlx_cmd_bridge.sv
dv/tb_tlx_cmd_bridge.sv

// File: dv/tb_tlx_cmd_bridge.sv
/*
 * testbench for the command bridge: random write and read traffic,
 * a reference model with its own credit counts, and a credit hold phase
 */
`timescale 1ns/1ns
`include "tlx_cmd_settings.svh"

module tb_tlx_cmd_bridge;

   import tlx_cmd_pkg::*;

   localparam int N_WR       = 200;
   localparam int N_RD       = 200;
   localparam int MAX_CYCLES = (N_WR + N_RD) * 50;
   localparam int HALF       = `TLX_QUEUE_DEPTH / 2;
   localparam int BEAT       = `TLX_BEAT_W;
   localparam int CMD_MAX    = (1 << `TLX_CMD_CREDIT_W) - 1;
   localparam int DATA_MAX   = (1 << `TLX_DATA_CREDIT_W) - 1;
   localparam int CMD_INIT   = 10;
   localparam int DATA_INIT  = 24;
   // credits stop once this many writes are in
   localparam int HOLD_AT    = 40;

   logic clk_tlx, rst_n;
   logic wr_valid, wr_ready, rd_valid, rd_ready;
   logic [`TLX_OPCODE_W-1:0] wr_opcode, rd_opcode, cmd_opcode;
   logic [`TLX_EA_W-1:0]     wr_ea_or_obj, rd_ea_or_obj, cmd_ea_or_obj;
   logic [`TLX_AFUTAG_W-1:0] wr_afutag, rd_afutag, cmd_afutag;
   logic [`TLX_DL_W-1:0]     wr_dl, rd_dl, cmd_dl;
   logic [`TLX_PL_W-1:0]     wr_pl, rd_pl, cmd_pl;
   logic [`TLX_ACTAG_W-1:0]  wr_actag, rd_actag, cmd_actag;
   logic [`TLX_PASID_W-1:0]  wr_pasid, rd_pasid, cmd_pasid;
   logic [2*BEAT-1:0]        wr_wdata;
   logic                     cmd_valid, cdata_valid, cmd_credit, data_credit;
   logic [BEAT-1:0]          cdata_bus;
   logic [`TLX_CMD_CREDIT_W-1:0]  cmd_initial_credit;
   logic [`TLX_DATA_CREDIT_W-1:0] data_initial_credit;
   logic [1:0]               fir_credit;

   // reference model state
   tlx_cmd_t          exp_wr_cmd[$];
   tlx_cmd_t          exp_rd_cmd[$];
   logic [2*BEAT-1:0] exp_wr_data[$];
   tlx_cmd_t          wr_exp;
   logic [2*BEAT-1:0] wr_data_exp;
   logic [BEAT-1:0]   upper_exp;
   logic              upper_due, next_upper, is_wr;
   logic              model_loaded, saw_wr_full, saw_rd_full;
   int                model_cmd, model_data, wr_occ, rd_occ;
   int                wr_pushed, rd_pushed, wr_done, rd_done, cycles, hold_phase;
   integer            seed = 32'h1118_a0cf;

   tlx_cmd_bridge i_tlx_cmd_bridge (.*);

   initial
   begin
      clk_tlx = 1'b0;
      forever #5 clk_tlx = ~clk_tlx;
   end

   //----------------------------------------------------------------------
   // failure reporting and compare helpers
   //----------------------------------------------------------------------
   task automatic report_failure(input string what);
      $display("%s", what);
      $display("Test failed");
      $fatal(1, "run stopped at the first error");
   endtask

   task automatic check_value(input string name, input logic [511:0] got,
                              input logic [511:0] exp);
      assert (got === exp)
      else report_failure($sformatf("mismatch at %0t ns: %s got %h expected %h",
                                    $time, name, got, exp));
   endtask

   task automatic check_cmd(input tlx_cmd_t exp);
      check_value("cmd_opcode", cmd_opcode, exp.opcode);
      check_value("cmd_ea_or_obj", cmd_ea_or_obj, exp.ea_or_obj);
      check_value("cmd_afutag", cmd_afutag, exp.afutag);
      check_value("cmd_dl", cmd_dl, exp.dl);
      check_value("cmd_pl", cmd_pl, exp.pl);
      check_value("cmd_actag", cmd_actag, exp.actag);
      check_value("cmd_pasid", cmd_pasid, exp.pasid);
   endtask

   function automatic logic [95:0] rand96();
      return {$random(seed), $random(seed), $random(seed)};
   endfunction

   // writes carry opcode bit 7 set, reads have it clear
   task automatic drive_write();
      logic [95:0]      r;
      logic [95:0]      e;
      logic [2*BEAT-1:0] data;
      r = rand96();
      e = rand96();
      for (int i = 0; i < 2 * BEAT / 32; i++)
      begin
         data[i*32 +: 32] = $random(seed);
      end
      wr_opcode    <= {1'b1, r[6:0]};
      wr_ea_or_obj <= e[67:0];
      wr_afutag    <= r[22:7];
      wr_pl        <= r[25:23];
      wr_actag     <= r[37:26];
      wr_pasid     <= r[57:38];
      wr_dl        <= r[58] ? 2'd2 : 2'd1;
      wr_wdata     <= data;
      wr_valid     <= 1'b1;
   endtask

   task automatic drive_read();
      logic [95:0] r;
      logic [95:0] e;
      r = rand96();
      e = rand96();
      rd_opcode    <= {1'b0, r[6:0]};
      rd_ea_or_obj <= e[67:0];
      rd_afutag    <= r[22:7];
      rd_pl        <= r[25:23];
      rd_actag     <= r[37:26];
      rd_pasid     <= r[57:38];
      rd_dl        <= r[58] ? 2'd2 : 2'd1;
      rd_valid     <= 1'b1;
   endtask

   //----------------------------------------------------------------------
   // per-cycle model, checks and stimulus
   //----------------------------------------------------------------------
   always @(posedge clk_tlx)
   begin
      if (!rst_n)
      begin
         assert (!cmd_valid && !cdata_valid && fir_credit == 2'b00 && wr_ready && rd_ready)
         else report_failure("outputs not in their reset state while rst_n is low");
      end
      else
      begin
         // counters load the initial credits in the first cycle out of reset
         if (!model_loaded)
         begin
            model_cmd    = CMD_INIT;
            model_data   = DATA_INIT;
            model_loaded = 1'b1;
         end
         else
         begin
            model_cmd  = model_cmd + int'(cmd_credit) - int'(cmd_valid);
            model_data = model_data + int'(data_credit) - int'(cdata_valid);
            assert (model_cmd >= 0 && model_data >= 0)
            else report_failure("bridge sent a command or beat with no credit left");
         end
         check_value("fir_credit", fir_credit, '0);

         is_wr      = cmd_valid && cmd_opcode[7];
         next_upper = 1'b0;
         if (upper_due)
         begin
            assert (!is_wr)
            else report_failure("write command issued while an upper beat was due");
            assert (cdata_valid) else report_failure("upper beat missing after a 128-byte write");
            check_value("cdata_bus", cdata_bus, upper_exp);
         end
         if (cmd_valid && !cmd_opcode[7])
         begin
            assert (exp_rd_cmd.size() > 0)
            else report_failure("read command with no read pending");
            check_cmd(exp_rd_cmd.pop_front());
            rd_done++;
            rd_occ--;
         end
         else if (is_wr)
         begin
            assert (exp_wr_cmd.size() > 0)
            else report_failure("write command with no write pending");
            wr_exp      = exp_wr_cmd.pop_front();
            wr_data_exp = exp_wr_data.pop_front();
            check_cmd(wr_exp);
            assert (cdata_valid) else report_failure("lower beat missing with a write command");
            check_value("cdata_bus", cdata_bus, wr_data_exp[BEAT-1:0]);
            // dl code 2 is a 128-byte write
            next_upper = (wr_exp.dl == 2'd2);
            upper_exp  = wr_data_exp[2*BEAT-1:BEAT];
            wr_done++;
            wr_occ--;
         end
         if (!upper_due && !is_wr)
         begin
            assert (!cdata_valid) else report_failure("data beat with no write behind it");
         end
         upper_due = next_upper;

         // ready follows the held entry count
         check_value("wr_ready", wr_ready, wr_occ < HALF);
         check_value("rd_ready", rd_ready, rd_occ < HALF);
         if (hold_phase == 1)
         begin
            saw_wr_full = saw_wr_full || !wr_ready;
            saw_rd_full = saw_rd_full || !rd_ready;
         end

         if (wr_valid && wr_ready)
         begin
            exp_wr_cmd.push_back('{wr_opcode, wr_ea_or_obj, wr_afutag, wr_dl, wr_pl,
                                   wr_actag, wr_pasid});
            exp_wr_data.push_back(wr_wdata);
            wr_occ++;
            wr_pushed++;
         end
         if (rd_valid && rd_ready)
         begin
            exp_rd_cmd.push_back('{rd_opcode, rd_ea_or_obj, rd_afutag, rd_dl, rd_pl,
                                   rd_actag, rd_pasid});
            rd_occ++;
            rd_pushed++;
         end

         // valid stays up until the push is taken
         if (!wr_valid || wr_ready)
         begin
            if (wr_pushed < N_WR && ($random(seed) & 3) != 0)
               drive_write();
            else
               wr_valid <= 1'b0;
         end
         if (!rd_valid || rd_ready)
         begin
            if (rd_pushed < N_RD && ($random(seed) & 3) != 0)
               drive_read();
            else
               rd_valid <= 1'b0;
         end

         // no credit returns while both queues back up
         if (hold_phase == 0 && wr_pushed >= HOLD_AT)
            hold_phase = 1;
         else if (hold_phase == 1 && saw_wr_full && saw_rd_full)
            hold_phase = 2;
         cmd_credit  <= (hold_phase != 1) && (model_cmd < CMD_MAX) && ($random(seed) & 1);
         data_credit <= (hold_phase != 1) && (model_data < DATA_MAX) && ($random(seed) & 1);
      end
   end

   always @(posedge clk_tlx)
   begin
      cycles++;
      assert (cycles < MAX_CYCLES)
      else report_failure($sformatf("timeout after %0d cycles, %0d writes and %0d reads seen",
                                    cycles, wr_done, rd_done));
   end

   initial
   begin
      rst_n               = 1'b1;
      wr_valid            = 1'b0;
      rd_valid            = 1'b0;
      {wr_opcode, wr_ea_or_obj, wr_afutag, wr_dl, wr_pl, wr_actag, wr_pasid} = '0;
      {rd_opcode, rd_ea_or_obj, rd_afutag, rd_dl, rd_pl, rd_actag, rd_pasid} = '0;
      wr_wdata            = '0;
      cmd_credit          = 1'b0;
      data_credit         = 1'b0;
      cmd_initial_credit  = CMD_INIT;
      data_initial_credit = DATA_INIT;
      upper_due           = 1'b0;
      model_loaded        = 1'b0;
      saw_wr_full         = 1'b0;
      saw_rd_full         = 1'b0;
      // falling reset edge ahead of the first clock edge
      #1 rst_n = 1'b0;
      repeat (4) @(posedge clk_tlx);
      rst_n <= 1'b1;
      wait (wr_done == N_WR && rd_done == N_RD);
      repeat (4) @(posedge clk_tlx);
      if (exp_wr_cmd.size() == 0 && exp_rd_cmd.size() == 0 && !upper_due &&
          saw_wr_full && saw_rd_full && fir_credit == 2'b00)
      begin
         $display("Test passed");
         $finish;
      end
      else
      begin
         report_failure("run ended with commands left or no full queue during the hold");
      end
   end

endmodule

// File: source/tlx_cmd_bridge.sv
/*
 * command bridge top: write and read queues feeding the issue stage,
 * with credit tracking toward the transaction layer
 */
`timescale 1ns/1ns
`include "tlx_cmd_settings.svh"

module tlx_cmd_bridge (
   input  logic                           clk_tlx,
   input  logic                           rst_n,
   // write channel
   input  logic                           wr_valid,
   output logic                           wr_ready,
   input  logic [`TLX_OPCODE_W-1:0]       wr_opcode,
   input  logic [`TLX_EA_W-1:0]           wr_ea_or_obj,
   input  logic [`TLX_AFUTAG_W-1:0]       wr_afutag,
   input  logic [`TLX_DL_W-1:0]           wr_dl,
   input  logic [`TLX_PL_W-1:0]           wr_pl,
   input  logic [`TLX_ACTAG_W-1:0]        wr_actag,
   input  logic [`TLX_PASID_W-1:0]        wr_pasid,
   input  logic [2*`TLX_BEAT_W-1:0]       wr_wdata,
   // read channel
   input  logic                           rd_valid,
   output logic                           rd_ready,
   input  logic [`TLX_OPCODE_W-1:0]       rd_opcode,
   input  logic [`TLX_EA_W-1:0]           rd_ea_or_obj,
   input  logic [`TLX_AFUTAG_W-1:0]       rd_afutag,
   input  logic [`TLX_DL_W-1:0]           rd_dl,
   input  logic [`TLX_PL_W-1:0]           rd_pl,
   input  logic [`TLX_ACTAG_W-1:0]        rd_actag,
   input  logic [`TLX_PASID_W-1:0]        rd_pasid,
   // command and data toward the transaction layer
   output logic                           cmd_valid,
   output logic [`TLX_OPCODE_W-1:0]       cmd_opcode,
   output logic [`TLX_EA_W-1:0]           cmd_ea_or_obj,
   output logic [`TLX_AFUTAG_W-1:0]       cmd_afutag,
   output logic [`TLX_DL_W-1:0]           cmd_dl,
   output logic [`TLX_PL_W-1:0]           cmd_pl,
   output logic [`TLX_ACTAG_W-1:0]        cmd_actag,
   output logic [`TLX_PASID_W-1:0]        cmd_pasid,
   output logic                           cdata_valid,
   output logic [`TLX_BEAT_W-1:0]         cdata_bus,
   // credits from the receiver
   input  logic                           cmd_credit,
   input  logic                           data_credit,
   input  logic [`TLX_CMD_CREDIT_W-1:0]   cmd_initial_credit,
   input  logic [`TLX_DATA_CREDIT_W-1:0]  data_initial_credit,
   output logic [1:0]                     fir_credit
);

   import tlx_cmd_pkg::*;

   wr_entry_t wr_entry, wr_head_entry;
   rd_entry_t rd_entry, rd_head_entry;
   tlx_cmd_t  cmd;
   logic      wr_head_valid, wr_pop;
   logic      rd_head_valid, rd_pop;

   credit_if crd ();

   //----------------------------------------------------------------------
   // pack channel fields into queue entries
   //----------------------------------------------------------------------
   assign wr_entry.cmd = '{wr_opcode, wr_ea_or_obj, wr_afutag, wr_dl, wr_pl, wr_actag, wr_pasid};
   assign wr_entry.data[0] = wr_wdata[`TLX_BEAT_W-1:0];
   assign wr_entry.data[1] = wr_wdata[2*`TLX_BEAT_W-1:`TLX_BEAT_W];
   assign rd_entry.cmd = '{rd_opcode, rd_ea_or_obj, rd_afutag, rd_dl, rd_pl, rd_actag, rd_pasid};

   cmd_queue #(.T(wr_entry_t)) i_wr_queue (
      .clk_tlx(clk_tlx), .rst_n(rst_n),
      .push_valid(wr_valid), .push_entry(wr_entry), .push_ready(wr_ready),
      .head_valid(wr_head_valid), .head_entry(wr_head_entry), .pop(wr_pop)
   );

   cmd_queue #(.T(rd_entry_t)) i_rd_queue (
      .clk_tlx(clk_tlx), .rst_n(rst_n),
      .push_valid(rd_valid), .push_entry(rd_entry), .push_ready(rd_ready),
      .head_valid(rd_head_valid), .head_entry(rd_head_entry), .pop(rd_pop)
   );

   cmd_issue i_cmd_issue (
      .clk_tlx(clk_tlx), .rst_n(rst_n),
      .wr_head_valid(wr_head_valid), .wr_head_entry(wr_head_entry), .wr_pop(wr_pop),
      .rd_head_valid(rd_head_valid), .rd_head_entry(rd_head_entry), .rd_pop(rd_pop),
      .crd(crd.issue),
      .cmd_valid(cmd_valid), .cmd(cmd),
      .cdata_valid(cdata_valid), .cdata_bus(cdata_bus)
   );

   credit_tracker i_credit_tracker (
      .clk_tlx(clk_tlx), .rst_n(rst_n), .crd(crd.tracker),
      .cmd_credit(cmd_credit), .data_credit(data_credit),
      .cmd_initial_credit(cmd_initial_credit), .data_initial_credit(data_initial_credit),
      .fir_credit(fir_credit)
   );

   // unpack the issued command onto the ports
   assign {cmd_opcode, cmd_ea_or_obj, cmd_afutag, cmd_dl, cmd_pl, cmd_actag, cmd_pasid} = cmd;

endmodule

// File: issue/credit_tracker.sv
/*
 * credit tracker: command and data credit counters,
 * registered issue flags and sticky breach bits
 */
`timescale 1ns/1ns
`include "tlx_cmd_settings.svh"

module credit_tracker (
   input  logic                          clk_tlx,
   input  logic                          rst_n,
   credit_if.tracker                     crd,
   input  logic                          cmd_credit,
   input  logic                          data_credit,
   input  logic [`TLX_CMD_CREDIT_W-1:0]  cmd_initial_credit,
   input  logic [`TLX_DATA_CREDIT_W-1:0] data_initial_credit,
   output logic [1:0]                    fir_credit
);

   localparam int CMD_W  = `TLX_CMD_CREDIT_W;
   localparam int DATA_W = `TLX_DATA_CREDIT_W;
   localparam logic [CMD_W-1:0]  CMD_RESERVE = `TLX_CMD_RESERVE;
   localparam logic [DATA_W-1:0] WR_MIN      = `TLX_WR_DATA_MIN;

   logic              loaded;
   logic [CMD_W-1:0]  cmd_cnt;
   logic [DATA_W-1:0] data_cnt;
   logic              cmd_breach;
   logic              data_breach;

   //----------------------------------------------------------------------
   // counters, loaded once in the first cycle out of reset
   //----------------------------------------------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         loaded   <= 1'b0;
         cmd_cnt  <= '0;
         data_cnt <= '0;
      end
      else if (!loaded)
      begin
         loaded   <= 1'b1;
         cmd_cnt  <= cmd_initial_credit;
         data_cnt <= data_initial_credit;
      end
      else
      begin
         case ({cmd_credit, crd.cmd_sent})
            2'b10:   cmd_cnt <= cmd_cnt + 1'b1;
            2'b01:   cmd_cnt <= cmd_cnt - 1'b1;
            default: cmd_cnt <= cmd_cnt;
         endcase
         case ({data_credit, crd.beat_sent})
            2'b10:   data_cnt <= data_cnt + 1'b1;
            2'b01:   data_cnt <= data_cnt - 1'b1;
            default: data_cnt <= data_cnt;
         endcase
      end
   end

   // flags lag the counts by a cycle, the reserve covers the lag
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         crd.cmd_ok  <= 1'b0;
         crd.wr_ok   <= 1'b0;
         cmd_breach  <= 1'b0;
         data_breach <= 1'b0;
      end
      else
      begin
         crd.cmd_ok <= (cmd_cnt > CMD_RESERVE);
         crd.wr_ok  <= (data_cnt >= WR_MIN);
         // sending with nothing left is a fault, held until reset
         if (crd.cmd_sent && (cmd_cnt == '0))
         begin
            cmd_breach <= 1'b1;
         end
         if (crd.beat_sent && (data_cnt == '0))
         begin
            data_breach <= 1'b1;
         end
      end
   end

   assign fir_credit = {cmd_breach, data_breach};

endmodule

// File: issue/cmd_issue.sv
/*
 * issue stage: alternates write and read slots, pops the queues
 * under credit control and drives the command and data beat lanes
 */
`timescale 1ns/1ns
`include "tlx_cmd_settings.svh"

module cmd_issue (
   input  logic                    clk_tlx,
   input  logic                    rst_n,

   // write queue head
   input  logic                    wr_head_valid,
   input  tlx_cmd_pkg::wr_entry_t  wr_head_entry,
   output logic                    wr_pop,

   // read queue head
   input  logic                    rd_head_valid,
   input  tlx_cmd_pkg::rd_entry_t  rd_head_entry,
   output logic                    rd_pop,

   credit_if.issue                 crd,

   // toward the transaction layer
   output logic                    cmd_valid,
   output tlx_cmd_pkg::tlx_cmd_t   cmd,
   output logic                    cdata_valid,
   output logic [`TLX_BEAT_W-1:0]  cdata_bus
);

   import tlx_cmd_pkg::*;

   logic                   slot;
   logic                   upper_pend;
   logic [`TLX_BEAT_W-1:0] upper_beat;

   //----------------------------------------------------------------------
   // slot alternation and pop decision
   //----------------------------------------------------------------------
   // write pops in even slots only, so its upper beat always
   // lands in the following odd slot and never meets another write
   assign wr_pop = !slot && wr_head_valid && crd.cmd_ok && crd.wr_ok;
   assign rd_pop = slot && rd_head_valid && crd.cmd_ok;

   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         slot        <= 1'b0;
         cmd_valid   <= 1'b0;
         cdata_valid <= 1'b0;
         upper_pend  <= 1'b0;
      end
      else
      begin
         slot        <= ~slot;
         cmd_valid   <= wr_pop || rd_pop;
         cdata_valid <= wr_pop || upper_pend;
         upper_pend  <= wr_pop && wr_head_entry.cmd.dl[DL_128B_BIT];
      end
   end

   //----------------------------------------------------------------------
   // command and data payload
   //----------------------------------------------------------------------
   always_ff @(posedge clk_tlx)
   begin
      if (wr_pop)
      begin
         cmd <= wr_head_entry.cmd;
      end
      else if (rd_pop)
      begin
         cmd <= rd_head_entry.cmd;
      end
   end

   // lower beat goes with the write command, upper beat waits a cycle
   always_ff @(posedge clk_tlx)
   begin
      if (wr_pop)
      begin
         cdata_bus  <= wr_head_entry.data[0];
         upper_beat <= wr_head_entry.data[1];
      end
      else if (upper_pend)
      begin
         cdata_bus <= upper_beat;
      end
   end

   // every output command and every beat costs one credit
   assign crd.cmd_sent  = cmd_valid;
   assign crd.beat_sent = cdata_valid;

endmodule

// File: source/cmd_queue.sv
/*
 * command queue: first-word-fall-through circular buffer,
 * push ready drops once half the entries are in use
 */
`timescale 1ns/1ns
`include "tlx_cmd_settings.svh"

module cmd_queue #(
   parameter type T     = logic,
   parameter int  DEPTH = `TLX_QUEUE_DEPTH
) (
   input  logic clk_tlx,
   input  logic rst_n,
   input  logic push_valid,
   input  T     push_entry,
   output logic push_ready,
   output logic head_valid,
   output T     head_entry,
   input  logic pop
);

   localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int CNT_W = $clog2(DEPTH + 1);
   localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
   localparam logic [CNT_W-1:0] HALF      = CNT_W'(DEPTH / 2);

   T                 mem [DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             do_push;
   logic             do_pop;

   // refuse pushes from half full on, the source sees ready low
   assign push_ready = (count < HALF);
   assign do_push    = push_valid && push_ready;
   assign do_pop     = pop && head_valid;

   assign head_valid = (count != '0);
   assign head_entry = mem[rd_ptr];

   always_ff @(posedge clk_tlx)
   begin
      if (do_push)
      begin
         mem[wr_ptr] <= push_entry;
      end
   end

   //----------------------------------------------------------------------
   // pointers and occupancy
   //----------------------------------------------------------------------
   always_ff @(posedge clk_tlx or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
         begin
            wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop)
         begin
            rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + 1'b1;
         end
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

endmodule

// File: common/credit_if.sv
/*
 * credit link between the issue stage and the credit tracker
 */
`timescale 1ns/1ns

interface credit_if;

   // one pulse per command and per data beat on the output
   logic cmd_sent;
   logic beat_sent;

   // registered go flags from the credit counts
   logic cmd_ok;
   logic wr_ok;

   modport issue (
      output cmd_sent,
      output beat_sent,
      input  cmd_ok,
      input  wr_ok
   );

   modport tracker (
      input  cmd_sent,
      input  beat_sent,
      output cmd_ok,
      output wr_ok
   );

endinterface

// File: common/tlx_cmd_pkg.sv
/*
 * command bridge types: transaction layer command fields
 * and the payloads held by the write and read queues
 */
`include "tlx_cmd_settings.svh"

package tlx_cmd_pkg;

   // dl code 1 is 64 bytes, code 2 is 128 bytes
   // so the upper dl bit alone calls for the second beat
   localparam int DL_128B_BIT = 1;

   //----------------------------------------------------------------------
   // command fields, 129 bits
   //----------------------------------------------------------------------
   typedef struct packed {
      logic [`TLX_OPCODE_W-1:0] opcode;
      logic [`TLX_EA_W-1:0]     ea_or_obj;
      logic [`TLX_AFUTAG_W-1:0] afutag;
      logic [`TLX_DL_W-1:0]     dl;
      logic [`TLX_PL_W-1:0]     pl;
      logic [`TLX_ACTAG_W-1:0]  actag;
      logic [`TLX_PASID_W-1:0]  pasid;
   } tlx_cmd_t;

   //----------------------------------------------------------------------
   // queue payloads
   //----------------------------------------------------------------------
   // data[0] is the lower 64B beat, data[1] the upper one
   typedef struct packed {
      tlx_cmd_t                         cmd;
      logic [1:0][`TLX_BEAT_W-1:0]      data;
   } wr_entry_t;

   typedef struct packed {
      tlx_cmd_t cmd;
   } rd_entry_t;

endpackage

// File: common/tlx_cmd_settings.svh
/*
 * command bridge settings: field widths, queue depth and credit thresholds
 */
`ifndef TLX_CMD_SETTINGS_SVH
`define TLX_CMD_SETTINGS_SVH

// command field widths
`define TLX_OPCODE_W      8
`define TLX_EA_W          68
`define TLX_AFUTAG_W      16
`define TLX_DL_W          2
`define TLX_PL_W          3
`define TLX_ACTAG_W       12
`define TLX_PASID_W       20

// one write data beat, a write carries two
`define TLX_BEAT_W        512

// entries per queue, ready drops at half
`define TLX_QUEUE_DEPTH   32

// credit counters and issue thresholds
`define TLX_CMD_CREDIT_W  4
`define TLX_DATA_CREDIT_W 6
`define TLX_CMD_RESERVE   3
`define TLX_WR_DATA_MIN   5

`endif
